// File: compile.f
hdl/scrmbl_pkg.sv
hdl/present_round.sv
hdl/scrmbl_state_regs.sv
hdl/scrmbl_fsm.sv
hdl/otp_scrmbl.sv
verification/scrmbl_checker.sv
verification/tb_otp_scrmbl.sv

// File: hdl/otp_scrmbl.sv
`timescale 1ns/1ps
`default_nettype none

module otp_scrmbl
  import scrmbl_pkg::*;
#(
  parameter int NumRounds = 31
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  scrmbl_req_t           req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [BlockWidth-1:0] data_o,
  output logic                  valid_o
);

  dp_ctrl_t              ctrl;
  logic [BlockWidth-1:0] data_state;
  logic [BlockWidth-1:0] rnd_data;
  key_word_u             key_state;
  key_word_u             rnd_key;

  // command decode and round sequencing
  scrmbl_fsm #(
    .NumRounds(NumRounds)
  ) u_fsm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .ctrl_o  (ctrl),
    .valid_o (valid_o)
  );

  // data, key, shadow and digest registers
  scrmbl_state_regs u_state_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ctrl_i       (ctrl),
    .req_i        (req_i),
    .rnd_data_i   (rnd_data),
    .rnd_key_i    (rnd_key),
    .data_state_o (data_state),
    .key_state_o  (key_state),
    .data_o       (data_o)
  );

  // single combinational cipher round
  present_round #(
    .NumRounds(NumRounds)
  ) u_present_round (
    .data_i      (data_state),
    .key_i       (key_state),
    .round_idx_i (ctrl.round_idx),
    .data_o      (rnd_data),
    .key_o       (rnd_key)
  );

endmodule

`default_nettype wire

// File: hdl/present_round.sv
`timescale 1ns/1ps
`default_nettype none

module present_round
  import scrmbl_pkg::*;
#(
  parameter int NumRounds = 31
) (
  input  logic [BlockWidth-1:0]  data_i,
  input  key_word_u              key_i,
  input  logic [RndIdxWidth-1:0] round_idx_i,
  output logic [BlockWidth-1:0]  data_o,
  output key_word_u              key_o
);

  // present s-box, entry 0 on the right
  localparam logic [15:0][3:0] Sbox4 = {
    4'h2, 4'h1, 4'h7, 4'h4, 4'h8, 4'hF, 4'hE, 4'h3,
    4'hD, 4'hA, 4'h0, 4'h9, 4'hB, 4'h6, 4'h5, 4'hC
  };

  localparam logic [RndIdxWidth-1:0] LastRound = RndIdxWidth'(NumRounds);

  // substitution on all 16 nibbles
  function automatic logic [BlockWidth-1:0] sbox_layer(input logic [BlockWidth-1:0] din);
    logic [BlockWidth-1:0] dout;
    for (int n = 0; n < BlockWidth / 4; n++) begin
      dout[4*n +: 4] = Sbox4[din[4*n +: 4]];
    end
    return dout;
  endfunction

  // bit i moves to 16*i mod 63, bit 63 stays
  function automatic logic [BlockWidth-1:0] perm_layer(input logic [BlockWidth-1:0] din);
    logic [BlockWidth-1:0] dout;
    for (int i = 0; i < BlockWidth - 1; i++) begin
      dout[(16 * i) % 63] = din[i];
    end
    dout[BlockWidth-1] = din[BlockWidth-1];
    return dout;
  endfunction

  // 128-bit key schedule step
  function automatic logic [KeyWidth-1:0] key_step(input logic [KeyWidth-1:0]    kin,
                                                   input logic [RndIdxWidth-1:0] idx);
    logic [KeyWidth-1:0] kout;
    // rotate left by 61
    kout = {kin[66:0], kin[127:67]};
    kout[127:124] = Sbox4[kout[127:124]];
    kout[123:120] = Sbox4[kout[123:120]];
    // round counter enters at bits 66..62
    kout[66:62] = kout[66:62] ^ idx;
    return kout;
  endfunction

  logic [BlockWidth-1:0] round_out;

  // add round key, then substitution and permutation
  assign round_out = perm_layer(sbox_layer(data_i ^ key_i.key[KeyWidth-1 -: BlockWidth]));

  assign key_o.key = key_step(key_i.key, round_idx_i);

  // final whitening with the next round key after the last round
  assign data_o = (round_idx_i == LastRound) ?
                  round_out ^ key_o.key[KeyWidth-1 -: BlockWidth] : round_out;

endmodule

`default_nettype wire

// File: hdl/scrmbl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module scrmbl_fsm
  import scrmbl_pkg::*;
#(
  parameter int NumRounds = 31
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  scrmbl_req_t req_i,
  input  logic        valid_i,
  output logic        ready_o,
  output dp_ctrl_t    ctrl_o,
  output logic        valid_o
);

  localparam logic [RndIdxWidth-1:0] LastRound = RndIdxWidth'(NumRounds);

  typedef enum logic [1:0] {
    IdleSt,
    EncryptSt,
    DigestSt
  } state_e;

  state_e                 state_d, state_q;
  logic [RndIdxWidth-1:0] rnd_cnt_d, rnd_cnt_q;
  digest_mode_e           mode_d, mode_q;
  logic                   valid_d, valid_q;

  assign valid_o = valid_q;

  always_comb begin : p_fsm
    state_d   = state_q;
    rnd_cnt_d = rnd_cnt_q;
    mode_d    = mode_q;
    valid_d   = 1'b0;
    ready_o   = 1'b0;

    // all enables off, data input and standard block as idle selection
    ctrl_o            = '0;
    ctrl_o.data_sel   = SelDataInput;
    ctrl_o.key_sel    = SelDigestInput;
    ctrl_o.round_idx  = rnd_cnt_q;
    ctrl_o.data_valid = valid_q;

    unique case (state_q)
      //////////////////////////////
      // idle, decode one command
      IdleSt: begin
        ready_o = 1'b1;
        if (valid_i) begin
          case (req_i.cmd)
            Encrypt: begin
              state_d        = EncryptSt;
              rnd_cnt_d      = RndIdxWidth'(1);
              ctrl_o.key_sel = SelKeyInit;
              ctrl_o.data_en = 1'b1;
              ctrl_o.key_en  = 1'b1;
            end
            LoadShadow: begin
              // chained mode reuses the last cipher result
              if (mode_q == ChainedMode) begin
                ctrl_o.shadow_copy = 1'b1;
              end else begin
                ctrl_o.shadow_load = 1'b1;
              end
            end
            Digest: begin
              state_d         = DigestSt;
              rnd_cnt_d       = RndIdxWidth'(1);
              ctrl_o.data_sel = SelDigestState;
              ctrl_o.key_sel  = (mode_q == ChainedMode) ? SelDigestChained : SelDigestInput;
              ctrl_o.data_en  = 1'b1;
              ctrl_o.key_en   = 1'b1;
            end
            DigestInit: begin
              mode_d             = req_i.mode;
              ctrl_o.digest_init = 1'b1;
              ctrl_o.digest_en   = 1'b1;
            end
            DigestFinalize: begin
              state_d         = DigestSt;
              rnd_cnt_d       = RndIdxWidth'(1);
              ctrl_o.data_sel = SelDigestState;
              ctrl_o.key_sel  = SelDigestConst;
              ctrl_o.data_en  = 1'b1;
              ctrl_o.key_en   = 1'b1;
              mode_d          = StandardMode;
            end
            default: ;
          endcase
        end
      end
      //////////////////////////////
      // cipher rounds, shared by encrypt and digest
      EncryptSt, DigestSt: begin
        ctrl_o.data_sel = SelRndData;
        ctrl_o.key_sel  = SelRndKey;
        ctrl_o.data_en  = 1'b1;
        ctrl_o.key_en   = 1'b1;
        if (rnd_cnt_q == LastRound) begin
          state_d = IdleSt;
          valid_d = 1'b1;
          // davies-meyer feed-forward, kept apart from the data state
          if (state_q == DigestSt) begin
            ctrl_o.data_sel  = SelRndDataXor;
            ctrl_o.digest_en = 1'b1;
          end
        end else begin
          rnd_cnt_d = rnd_cnt_q + RndIdxWidth'(1);
        end
      end
      default: begin
        state_d = IdleSt;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q   <= IdleSt;
      rnd_cnt_q <= '0;
      mode_q    <= StandardMode;
      valid_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      rnd_cnt_q <= rnd_cnt_d;
      mode_q    <= mode_d;
      valid_q   <= valid_d;
    end
  end

  // round index has to fit the 5-bit key schedule counter
  num_rounds_range_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (NumRounds >= 1) && (NumRounds <= 31));

  // only existing keys may be picked
  enc_key_sel_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && ready_o && req_i.cmd == Encrypt) |-> (req_i.sel < NumKeys));

  // busy for all rounds, then one result pulse
  enc_latency_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && ready_o && req_i.cmd == Encrypt)
    |=> !ready_o [*NumRounds] ##1 (valid_o && ready_o));

endmodule

`default_nettype wire

// File: hdl/scrmbl_pkg.sv
`default_nettype none

package scrmbl_pkg;

  // datapath widths
  localparam int BlockWidth    = 64;
  localparam int KeyWidth      = 128;
  localparam int NumKeys       = 3;
  localparam int NumDigestSets = 2;
  localparam int SelWidth      = 2;
  localparam int RndIdxWidth   = 5;

  // scrambling keys, one per partition class
  localparam logic [KeyWidth-1:0] ScrmblKeys [NumKeys] = '{
    128'h7C3A_91E4_0F5B_D286_A1C9_3E70_5BD4_812F,
    128'hE05D_2B97_C641_8AF3_1D7E_9054_B2C8_6A3D,
    128'h49F1_A63C_D08E_5712_8B2D_F47A_0C96_E35B
  };

  // digest finalization constants
  localparam logic [KeyWidth-1:0] DigestConsts [NumDigestSets] = '{
    128'h9A2E_F513_64B8_0DC7_3F81_AE29_D750_6C14,
    128'h15C7_8D3A_E2F0_496B_70AD_5C1E_B386_F924
  };

  // digest initialization vectors
  localparam logic [BlockWidth-1:0] DigestIvs [NumDigestSets] = '{
    64'hB4E3_17A9_5C02_F86D,
    64'h2D90_6F4B_C8E1_3A75
  };

  // code 0 stays unused, it used to be decrypt
  typedef enum logic [2:0] {
    Encrypt        = 3'd1,
    LoadShadow     = 3'd2,
    Digest         = 3'd3,
    DigestInit     = 3'd4,
    DigestFinalize = 3'd5
  } scrmbl_cmd_e;

  typedef enum logic {
    StandardMode = 1'b0,
    ChainedMode  = 1'b1
  } digest_mode_e;

  typedef struct packed {
    scrmbl_cmd_e             cmd;
    digest_mode_e            mode;
    logic [SelWidth-1:0]     sel;
    logic [BlockWidth-1:0]   data;
  } scrmbl_req_t;

  // next value of the data state register
  typedef enum logic [1:0] {
    SelRndData,
    SelDigestState,
    SelRndDataXor,
    SelDataInput
  } data_sel_e;

  // next value of the key state register
  typedef enum logic [2:0] {
    SelRndKey,
    SelKeyInit,
    SelDigestConst,
    SelDigestInput,
    SelDigestChained
  } key_sel_e;

  typedef struct packed {
    data_sel_e              data_sel;
    key_sel_e               key_sel;
    logic                   data_en;
    logic                   key_en;
    logic                   digest_en;
    logic                   shadow_copy;
    logic                   shadow_load;
    logic                   digest_init;
    logic                   data_valid;
    logic [RndIdxWidth-1:0] round_idx;
  } dp_ctrl_t;

  // same 128 bits, either a cipher key or a two-word digest block
  typedef union packed {
    logic [KeyWidth-1:0] key;
    struct packed {
      logic [BlockWidth-1:0] hi;
      logic [BlockWidth-1:0] lo;
    } blk;
  } key_word_u;

endpackage

`default_nettype wire

// File: hdl/scrmbl_state_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scrmbl_state_regs
  import scrmbl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dp_ctrl_t              ctrl_i,
  input  scrmbl_req_t           req_i,
  input  logic [BlockWidth-1:0] rnd_data_i,
  input  key_word_u             rnd_key_i,
  output logic [BlockWidth-1:0] data_state_o,
  output key_word_u             key_state_o,
  output logic [BlockWidth-1:0] data_o
);

  // tables padded to the full sel range, unused slots read zero
  localparam int NumSel = 2**SelWidth;

  logic [KeyWidth-1:0]   key_lut   [NumSel];
  logic [KeyWidth-1:0]   const_lut [NumSel];
  logic [BlockWidth-1:0] iv_lut    [NumSel];

  logic [BlockWidth-1:0] data_state_d, data_state_q;
  logic [BlockWidth-1:0] shadow_q;
  logic [BlockWidth-1:0] digest_state_d, digest_state_q;
  logic [BlockWidth-1:0] dm_xor;
  key_word_u             key_state_d, key_state_q;

  ////////////////////////////
  // constant lookup
  always_comb begin : p_luts
    for (int k = 0; k < NumSel; k++) begin
      key_lut[k]   = '0;
      const_lut[k] = '0;
      iv_lut[k]    = '0;
    end
    for (int k = 0; k < NumKeys; k++) begin
      key_lut[k] = ScrmblKeys[k];
    end
    for (int k = 0; k < NumDigestSets; k++) begin
      const_lut[k] = DigestConsts[k];
      iv_lut[k]    = DigestIvs[k];
    end
  end

  ////////////////////////////
  // next-state selection

  // davies-meyer, cipher output xor chaining value
  assign dm_xor = rnd_data_i ^ digest_state_q;

  always_comb begin : p_data_mux
    unique case (ctrl_i.data_sel)
      SelRndData:     data_state_d = rnd_data_i;
      SelDigestState: data_state_d = digest_state_q;
      SelRndDataXor:  data_state_d = dm_xor;
      default:        data_state_d = req_i.data;
    endcase
  end

  always_comb begin : p_key_mux
    key_state_d = rnd_key_i;
    unique case (ctrl_i.key_sel)
      SelRndKey: begin
        key_state_d = rnd_key_i;
      end
      SelKeyInit: begin
        key_state_d.key = key_lut[req_i.sel];
      end
      SelDigestConst: begin
        key_state_d.key = const_lut[req_i.sel];
      end
      SelDigestChained: begin
        // last cipher result on top of the shadow word
        key_state_d.blk.hi = data_state_q;
        key_state_d.blk.lo = shadow_q;
      end
      default: begin
        // standard block, new input word on top of the shadow word
        key_state_d.blk.hi = req_i.data;
        key_state_d.blk.lo = shadow_q;
      end
    endcase
  end

  // iv on digest init, else the updated chaining value
  assign digest_state_d = ctrl_i.digest_init ? iv_lut[req_i.sel] : dm_xor;

  ////////////////////////////
  // working registers
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data_state_q   <= '0;
      key_state_q    <= '0;
      shadow_q       <= '0;
      digest_state_q <= '0;
    end else begin
      if (ctrl_i.data_en) begin
        data_state_q <= data_state_d;
      end
      if (ctrl_i.key_en) begin
        key_state_q <= key_state_d;
      end
      if (ctrl_i.shadow_copy) begin
        shadow_q <= data_state_q;
      end else if (ctrl_i.shadow_load) begin
        shadow_q <= req_i.data;
      end
      if (ctrl_i.digest_en) begin
        digest_state_q <= digest_state_d;
      end
    end
  end

  assign data_state_o = data_state_q;
  assign key_state_o  = key_state_q;

  // result visible during the valid pulse only
  assign data_o = ctrl_i.data_valid ? data_state_q : '0;

  // finalization constant has to exist for the requested set
  digest_const_sel_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_i.key_en && ctrl_i.key_sel == SelDigestConst) |-> (req_i.sel < NumDigestSets));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_otp_scrmbl -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1

// File: verification/scrmbl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module scrmbl_checker
  import scrmbl_pkg::*;
#(
  parameter int NumRounds = 31
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire scrmbl_req_t           req_i,
  input  wire logic                  valid_i,
  input  wire logic                  ready_i,
  input  wire logic [BlockWidth-1:0] data_i,
  input  wire logic                  valid_out_i
);

  // present s-box, entry for input 0 first
  localparam logic [3:0] SboxTable [16] = '{
    4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
    4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };

  // rows handed over by the driver, popped at the accept edge
  logic [127:0] name_q [$];
  bit           out_q  [$];

  int tests_run;
  int tests_failed;
  int errors;

  // reference state of the scrambler
  logic [BlockWidth-1:0] m_data;
  logic [BlockWidth-1:0] m_shadow;
  logic [BlockWidth-1:0] m_digest;
  bit                    m_chained;

  bit                    busy;
  bit                    reset_checked;
  int                    wait_cnt;
  logic [127:0]          cur_name;
  logic [BlockWidth-1:0] cur_exp;
  bit                    cur_bad;

  task automatic push_row(input logic [127:0] name, input bit out);
    name_q.push_back(name);
    out_q.push_back(out);
  endtask

  function automatic logic [3:0] sbox_nibble(input logic [3:0] x);
    return SboxTable[x];
  endfunction

  // full cipher, round key taken from the top half of the key register
  function automatic logic [63:0] present_encrypt(input logic [63:0] pt, input logic [127:0] key);
    logic [63:0]  st;
    logic [63:0]  tmp;
    logic [127:0] k;
    st = pt;
    k  = key;
    for (int r = 1; r <= NumRounds; r++) begin
      st = st ^ k[127:64];
      for (int n = 0; n < 16; n++) begin
        st[4*n +: 4] = sbox_nibble(st[4*n +: 4]);
      end
      for (int i = 0; i < 64; i++) begin
        tmp[(i % 4) * 16 + i / 4] = st[i];
      end
      st = tmp;
      // key register rotated left by 61 positions
      k = (k << 61) | (k >> 67);
      k[127:124] = sbox_nibble(k[127:124]);
      k[123:120] = sbox_nibble(k[123:120]);
      k[66:62]   = k[66:62] ^ 5'(r);
    end
    return st ^ k[127:64];
  endfunction

  // update the reference state for one command, return its result
  function automatic logic [63:0] apply_command(input scrmbl_req_t req);
    logic [127:0] key;
    logic [63:0]  res;
    res = '0;
    case (req.cmd)
      Encrypt: begin
        res    = present_encrypt(req.data, ScrmblKeys[req.sel]);
        m_data = res;
      end
      LoadShadow: begin
        m_shadow = m_chained ? m_data : req.data;
      end
      DigestInit: begin
        m_chained = (req.mode == ChainedMode);
        m_digest  = DigestIvs[req.sel];
      end
      Digest, DigestFinalize: begin
        if (req.cmd == DigestFinalize) begin
          key = DigestConsts[req.sel];
        end else begin
          key = {m_chained ? m_data : req.data, m_shadow};
        end
        // davies-meyer feed-forward
        res      = present_encrypt(m_digest, key) ^ m_digest;
        m_digest = res;
        m_data   = res;
        if (req.cmd == DigestFinalize) begin
          m_chained = 1'b0;
        end
      end
      default: ;
    endcase
    return res;
  endfunction

  // outputs sampled mid-cycle, where they are stable
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      busy          = 1'b0;
      reset_checked = 1'b0;
      m_data        = '0;
      m_shadow      = '0;
      m_digest      = '0;
      m_chained     = 1'b0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        tests_run++;
        if (ready_i !== 1'b1 || valid_out_i !== 1'b0) begin
          $display("reset: ready_o is not high or valid_o is not low after reset");
          tests_failed++;
        end else begin
          $display("PASS reset");
        end
      end
      if (valid_out_i !== 1'b1 && data_i !== '0) begin
        $display("data_o is not zero while valid_o is low");
        errors++;
      end
      if (busy) begin
        wait_cnt++;
        if (valid_out_i === 1'b1) begin
          busy = 1'b0;
          if (wait_cnt != NumRounds + 1) begin
            $display("%0s: result came %0d cycles after accept instead of %0d",
                     cur_name, wait_cnt, NumRounds + 1);
            cur_bad = 1'b1;
          end
          if (data_i !== cur_exp) begin
            $display("CHECK FAILED %0s expected %h actual %h", cur_name, cur_exp, data_i);
            cur_bad = 1'b1;
          end
          tests_run++;
          if (cur_bad) begin
            tests_failed++;
            $display("FAIL %0s", cur_name);
          end else begin
            $display("PASS %0s", cur_name);
          end
        end else if (ready_i === 1'b1) begin
          $display("%0s: ready_o went high before the result", cur_name);
          tests_run++;
          tests_failed++;
          busy = 1'b0;
        end else if (wait_cnt > NumRounds + 1) begin
          $display("%0s: no valid_o pulse arrived", cur_name);
          tests_run++;
          tests_failed++;
          busy = 1'b0;
        end
      end else if (valid_out_i === 1'b1) begin
        $display("valid_o pulsed with no command running");
        errors++;
      end else if (ready_i !== 1'b1) begin
        $display("ready_o is low with no command running");
        errors++;
      end
      // command is taken at the next rising edge
      if (valid_i === 1'b1 && ready_i === 1'b1) begin
        if (name_q.size() == 0) begin
          $display("command accepted with no expected row queued");
          errors++;
        end else begin
          cur_name = name_q.pop_front();
          cur_exp  = apply_command(req_i);
          cur_bad  = 1'b0;
          if (out_q.pop_front()) begin
            busy     = 1'b1;
            wait_cnt = 0;
          end else begin
            tests_run++;
            $display("PASS %0s", cur_name);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/scrmbl_input.dat
# name cmd mode sel data(hex) out
# out: 1 when a valid_o result is expected, the value comes from the reference model
enc_k0       ENC    0 0 0123456789abcdef 1
enc_k1       ENC    0 1 fedcba9876543210 1
enc_k2       ENC    0 2 0000000000000000 1
enc_k0_ones  ENC    0 0 ffffffffffffffff 1
init_s0      INIT   0 0 0000000000000000 0
shadow_s0    LOAD   0 0 1122334455667788 0
digest_s0    DIGEST 0 0 99aabbccddeeff00 1
final_s0     FINAL  0 0 0000000000000000 1
init_s1      INIT   0 1 0000000000000000 0
shadow_s1a   LOAD   0 0 a5a5a5a55a5a5a5a 0
digest_s1a   DIGEST 0 0 0f1e2d3c4b5a6978 1
shadow_s1b   LOAD   0 0 c3d2e1f011223344 0
digest_s1b   DIGEST 0 0 8796a5b4c3d2e1f0 1
final_s1     FINAL  0 1 0000000000000000 1
init_c       INIT   1 0 0000000000000000 0
enc_c0       ENC    0 1 13579bdf2468ace0 1
shadow_c     LOAD   1 0 0000000000000000 0
enc_c1       ENC    0 2 deadbeefcafef00d 1
digest_c     DIGEST 1 0 0000000000000000 1
final_c      FINAL  0 0 0000000000000000 1
enc_after    ENC    0 1 0000000000000001 1

// File: verification/tb_otp_scrmbl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_otp_scrmbl
  import scrmbl_pkg::*;
;

  localparam int NumRounds = 31;
  localparam int ClkPeriod = 20;

  logic                  clk;
  logic                  rst_n;
  scrmbl_req_t           req;
  logic                  valid_in;
  logic                  ready;
  logic [BlockWidth-1:0] data_out;
  logic                  valid_out;

  // rows of the stimulus file
  logic [127:0]          row_name [$];
  scrmbl_cmd_e           row_cmd  [$];
  bit                    row_mode [$];
  logic [SelWidth-1:0]   row_sel  [$];
  logic [BlockWidth-1:0] row_data [$];
  bit                    row_out  [$];

  longint timeout_ns;

  otp_scrmbl #(
    .NumRounds(NumRounds)
  ) dut (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .req_i   (req),
    .valid_i (valid_in),
    .ready_o (ready),
    .data_o  (data_out),
    .valid_o (valid_out)
  );

  scrmbl_checker #(
    .NumRounds(NumRounds)
  ) chk (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .valid_i     (valid_in),
    .ready_i     (ready),
    .data_i      (data_out),
    .valid_out_i (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  function automatic scrmbl_cmd_e cmd_from_name(input logic [47:0] s);
    scrmbl_cmd_e c;
    case (s)
      "ENC":    c = Encrypt;
      "LOAD":   c = LoadShadow;
      "DIGEST": c = Digest;
      "INIT":   c = DigestInit;
      default:  c = DigestFinalize;
    endcase
    return c;
  endfunction

  task automatic read_rows(output bit ok);
    int           fd;
    int           cnt;
    string        line;
    logic [127:0] name;
    logic [47:0]  cmd;
    int           mode;
    int           sel;
    logic [63:0]  data;
    int           out;
    ok = 1'b0;
    fd = $fopen("verification/scrmbl_input.dat", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file verification/scrmbl_input.dat");
    end else begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          cnt = $sscanf(line, "%s %s %d %d %h %d", name, cmd, mode, sel, data, out);
          if (cnt == 6) begin
            row_name.push_back(name);
            row_cmd.push_back(cmd_from_name(cmd));
            row_mode.push_back(mode != 0);
            row_sel.push_back(SelWidth'(sel));
            row_data.push_back(data);
            row_out.push_back(out != 0);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // wait for ready, then hold the command for one cycle
  task automatic send_row(input int i);
    @(posedge clk);
    #2;
    while (ready !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    chk.push_row(row_name[i], row_out[i]);
    req.cmd  = row_cmd[i];
    req.mode = row_mode[i] ? ChainedMode : StandardMode;
    req.sel  = row_sel[i];
    req.data = row_data[i];
    valid_in = 1'b1;
    @(posedge clk);
    #2;
    // command word stays on req_i, only valid_i drops
    valid_in = 1'b0;
  endtask

  initial begin
    int idle;
    bit file_ok;
    void'($urandom(37));
    timeout_ns = 0;
    rst_n      = 1'b0;
    valid_in   = 1'b0;
    req        = '0;
    read_rows(file_ok);
    if (!file_ok) begin
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      timeout_ns = longint'(row_name.size()) * (NumRounds + 8) * ClkPeriod * 2
                   + 16 * ClkPeriod;
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < row_name.size(); i++) begin
        idle = int'($urandom % 4);
        repeat (idle) @(posedge clk);
        send_row(i);
      end
      // wait for the last result
      while (chk.busy) begin
        @(posedge clk);
      end
      repeat (2) @(posedge clk);
      $display("tests %0d, failed %0d, other errors %0d",
               chk.tests_run, chk.tests_failed, chk.errors);
      if (chk.tests_failed == 0 && chk.errors == 0 && chk.name_q.size() == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("timeout: the run did not finish in %0d ns", timeout_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
